//--- bench/decode_stage_properties.sv
`timescale 1ns/1ps

module decode_stage_properties #(
    parameter int DEPTH = 4
) (
    input logic        clk,
    input logic        rst,
    input logic        pop,
    input logic        empty,
    input logic        entry_valid,
    input logic        overflow,
    input logic [31:0] level,
    input logic        issue_valid
);

    pop_needs_entry: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop raised while the queue is empty");

    overflow_when_full: assert property (@(posedge clk) disable iff (rst)
        overflow |-> entry_valid && (level == DEPTH))
        else $error("overflow raised without a push into a full queue");

    // The issue register is cleared by reset, so nothing can leave in the next cycle
    quiet_after_reset: assert property (@(posedge clk) rst |=> !issue_valid)
        else $error("issue_valid raised in the cycle after reset");

endmodule

bind decode_queue decode_stage_properties #(.DEPTH(QUEUE_DEPTH)) queue_props (
    .clk         (clk),
    .rst         (rst),
    .pop         (pop),
    .empty       (empty),
    .entry_valid (entry_valid),
    .overflow    (overflow),
    .level       (32'(count)),
    .issue_valid (1'b0)
);

bind issue_unit decode_stage_properties issue_props (
    .clk         (clk),
    .rst         (rst),
    .pop         (pop),
    .empty       (empty),
    .entry_valid (1'b0),
    .overflow    (1'b0),
    .level       (32'd0),
    .issue_valid (issue_valid)
);

//--- bench/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
    import isa_pkg::*;
    import decode_pkg::*;

    localparam int QUEUE_DEPTH = 4;

    typedef struct packed {
        instr_id_t id;
        format_t   format;
        ifunc_t    ifunc;
        reg_addr_t dest;
        logic      reg_write;
    } golden_t;

    typedef struct packed {
        int row;
        int fetch_cycle;
    } pending_t;

    logic          clk;
    logic          rst;
    logic          fetch_valid;
    instr_word_t   instr_word;
    logic          issue_ready;
    logic          issue_valid;
    issued_entry_t issued;
    logic          overflow;

    string       names[$];
    instr_word_t words[$];
    golden_t     golden[$];
    pending_t    pending_q[$];

    int   errors = 0;
    int   checks = 0;
    int   cycle = 0;
    int   max_cycles = 1000;
    int   fetch_count = 0;
    int   settled_count = 0;
    int   issued_count = 0;
    int   overflow_count = 0;
    int   dropped_row = -1;
    int   cur_row = 0;
    logic random_ready = 1'b0;
    logic pend_fetch = 1'b0;
    int   pend_row = 0;
    int   pend_cycle = 0;

    decode_stage #(.QUEUE_DEPTH(QUEUE_DEPTH)) uut (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .instr_word  (instr_word),
        .issue_ready (issue_ready),
        .issue_valid (issue_valid),
        .issued      (issued),
        .overflow    (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ########################################################################
    // Helpers
    // ########################################################################

    function automatic instr_word_t r_word(input opcode_t op, input reg_addr_t rs,
                                           input reg_addr_t rt, input reg_addr_t rd,
                                           input logic [4:0] sh, input funct_t fn);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic instr_word_t i_word(input opcode_t op, input reg_addr_t rs,
                                           input reg_addr_t rt, input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic instr_word_t j_word(input opcode_t op, input logic [25:0] target);
        return {op, target};
    endfunction

    task automatic add_row(input string name, input instr_word_t word, input instr_id_t id,
                           input format_t fmt, input ifunc_t fn, input reg_addr_t dest,
                           input logic wr);
        names.push_back(name);
        words.push_back(word);
        golden.push_back('{id: id, format: fmt, ifunc: fn, dest: dest, reg_write: wr});
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_and_finish();
        $display("checks %0d errors %0d issued %0d overflows %0d",
                 checks, errors, issued_count, overflow_count);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    endtask

    // Every call returns 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (random_ready)
            issue_ready = 1'($urandom_range(1, 0));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic fetch_row(input int row);
        fetch_valid = 1'b1;
        instr_word  = words[row];
        cur_row     = row;
        fetch_count++;
        next_cycle();
        fetch_valid = 1'b0;
    endtask

    task automatic wait_settled();
        while (settled_count != fetch_count)
            next_cycle();
    endtask

    task automatic wait_drained();
        while (settled_count != fetch_count || pending_q.size() != 0)
            next_cycle();
    endtask

    task automatic compare_entry(input pending_t p);
        golden_t g;
        g = golden[p.row];
        check_value({names[p.row], ".id"}, 32'(g.id), 32'(issued.id));
        check_value({names[p.row], ".format"}, 32'(g.format), 32'(issued.format));
        check_value({names[p.row], ".ifunc"}, 32'(g.ifunc), 32'(issued.ifunc));
        check_value({names[p.row], ".reg_write"}, 32'(g.reg_write), 32'(issued.reg_write));
        check_value({names[p.row], ".rs"}, 32'(words[p.row][25:21]), 32'(issued.rs));
        check_value({names[p.row], ".rt"}, 32'(words[p.row][20:16]), 32'(issued.rt));
        check_value({names[p.row], ".imm"}, 32'(words[p.row][15:0]), 32'(issued.imm));
        if (g.reg_write)
            check_value({names[p.row], ".dest"}, 32'(g.dest), 32'(issued.dest));
        if (cycle - p.fetch_cycle < 3) begin
            errors++;
            $display("ERROR: %s issued %0d cycles after its fetch, sooner than allowed",
                     names[p.row], cycle - p.fetch_cycle);
        end
    endtask

    task automatic build_table();
        add_row("nop", r_word(OP_SPECIAL, 0, 0, 0, 0, FN_SLL), INSTR_NOP, FORMAT_R, I_ALU_R, 0, 0);
        add_row("add", r_word(OP_SPECIAL, 1, 2, 3, 0, FN_ADD), INSTR_ADD, FORMAT_R, I_ALU_R, 3, 1);
        add_row("add_r0", r_word(OP_SPECIAL, 1, 2, 0, 0, FN_ADD), INSTR_ADD, FORMAT_R, I_ALU_R, 0, 0);
        add_row("sub", r_word(OP_SPECIAL, 4, 5, 6, 0, FN_SUB), INSTR_SUB, FORMAT_R, I_ALU_R, 6, 1);
        add_row("addu", r_word(OP_SPECIAL, 7, 8, 9, 0, FN_ADDU), INSTR_ADDU, FORMAT_R, I_ALU_R, 9, 1);
        add_row("subu", r_word(OP_SPECIAL, 2, 3, 10, 0, FN_SUBU), INSTR_SUBU, FORMAT_R, I_ALU_R, 10, 1);
        add_row("and", r_word(OP_SPECIAL, 1, 1, 11, 0, FN_AND), INSTR_AND, FORMAT_R, I_ALU_R, 11, 1);
        add_row("xor", r_word(OP_SPECIAL, 3, 4, 13, 0, FN_XOR), INSTR_XOR, FORMAT_R, I_ALU_R, 13, 1);
        add_row("slt", r_word(OP_SPECIAL, 7, 8, 15, 0, FN_SLT), INSTR_SLT, FORMAT_R, I_ALU_R, 15, 1);
        add_row("sll", r_word(OP_SPECIAL, 0, 2, 7, 4, FN_SLL), INSTR_SLL, FORMAT_R, I_ALU_R, 7, 1);
        add_row("sra", r_word(OP_SPECIAL, 0, 4, 17, 31, FN_SRA), INSTR_SRA, FORMAT_R, I_ALU_R, 17, 1);
        add_row("srlv", r_word(OP_SPECIAL, 5, 6, 18, 0, FN_SRLV), INSTR_SRLV, FORMAT_R, I_ALU_R, 18, 1);
        add_row("clz", r_word(OP_SPECIAL2, 9, 0, 19, 0, FN_CLZ), INSTR_CLZ, FORMAT_R, I_ALU_R, 19, 1);
        add_row("addi", i_word(OP_ADDI, 1, 20, 16'h0010), INSTR_ADDI, FORMAT_I, I_ALU_I, 20, 1);
        add_row("addiu", i_word(OP_ADDIU, 2, 21, 16'hfffc), INSTR_ADDIU, FORMAT_I, I_ALU_I, 21, 1);
        add_row("andi", i_word(OP_ANDI, 3, 22, 16'h00ff), INSTR_ANDI, FORMAT_I, I_ALU_I, 22, 1);
        add_row("ori", i_word(OP_ORI, 4, 23, 16'h8001), INSTR_ORI, FORMAT_I, I_ALU_I, 23, 1);
        add_row("lui", i_word(OP_LUI, 0, 25, 16'h1234), INSTR_LUI, FORMAT_I, I_ALU_I, 25, 1);
        add_row("slti", i_word(OP_SLTI, 5, 26, 16'h0007), INSTR_SLTI, FORMAT_I, I_ALU_I, 26, 1);
        add_row("lw", i_word(OP_LW, 29, 12, 16'h0004), INSTR_LW, FORMAT_I, I_MEM_R, 12, 1);
        add_row("lbu", i_word(OP_LBU, 29, 14, 16'h0003), INSTR_LBU, FORMAT_I, I_MEM_R, 14, 1);
        add_row("sw", i_word(OP_SW, 29, 12, 16'h0008), INSTR_SW, FORMAT_I, I_MEM_W, 0, 0);
        add_row("sb", i_word(OP_SB, 29, 13, 16'h0001), INSTR_SB, FORMAT_I, I_MEM_W, 0, 0);
        add_row("beq", i_word(OP_BEQ, 1, 2, 16'h0003), INSTR_BEQ, FORMAT_I, I_BRANCH, 0, 0);
        add_row("bltz", i_word(OP_REGIMM, 3, RT_BLTZ, 16'hfff0), INSTR_BLTZ, FORMAT_I, I_BRANCH, 0, 0);
        add_row("bgezal", i_word(OP_REGIMM, 3, RT_BGEZAL, 16'h0020), INSTR_BGEZAL, FORMAT_I,
                I_BRANCH, 31, 1);
        add_row("j", j_word(OP_J, 26'h0000100), INSTR_J, FORMAT_J, I_JUMP, 0, 0);
        add_row("jal", j_word(OP_JAL, 26'h0000200), INSTR_JAL, FORMAT_J, I_JUMP, 31, 1);
        add_row("jr", r_word(OP_SPECIAL, 31, 0, 0, 0, FN_JR), INSTR_JR, FORMAT_R, I_JUMP, 0, 0);
        add_row("jalr", r_word(OP_SPECIAL, 4, 0, 9, 0, FN_JALR), INSTR_JALR, FORMAT_R, I_JUMP, 9, 1);
        add_row("mult", r_word(OP_SPECIAL, 5, 6, 0, 0, FN_MULT), INSTR_MULT, FORMAT_R, I_MD, 0, 0);
        add_row("mfhi", r_word(OP_SPECIAL, 0, 0, 10, 0, FN_MFHI), INSTR_MFHI, FORMAT_R, I_MD, 10, 1);
        add_row("mflo", r_word(OP_SPECIAL, 0, 0, 11, 0, FN_MFLO), INSTR_MFLO, FORMAT_R, I_MD, 11, 1);
        add_row("madd", r_word(OP_SPECIAL2, 4, 5, 0, 0, FN_MADD), INSTR_MADD, FORMAT_R, I_MD, 0, 0);
        add_row("mfc0", r_word(OP_COP0, RS_MF, 13, 12, 0, 0), INSTR_MFC0, FORMAT_R, I_CP0, 13, 1);
        add_row("mtc0", r_word(OP_COP0, RS_MT, 14, 12, 0, 0), INSTR_MTC0, FORMAT_R, I_CP0, 0, 0);
        add_row("eret", r_word(OP_COP0, RS_CO, 0, 0, 0, FN_ERET), INSTR_ERET, FORMAT_R, I_CP0, 0, 0);
        add_row("bad_op", i_word(6'h3f, 1, 2, 16'h0000), INSTR_INVALID, FORMAT_R, I_OTHER, 0, 0);
        add_row("bad_funct", r_word(OP_SPECIAL, 1, 2, 3, 0, 6'h3f), INSTR_INVALID, FORMAT_R,
                I_OTHER, 0, 0);
    endtask

    // ########################################################################
    // Monitor and timeout
    // ########################################################################

    // Sampled at the falling edge, half a cycle after inputs and registers settle
    always @(negedge clk) begin : monitor
        pending_t p;
        int       occupancy;
        logic     expect_ovf;
        if (!rst) begin
            if (pend_fetch) begin
                // Entries accepted earlier that have not been popped yet
                occupancy  = pending_q.size() - int'(issue_valid);
                expect_ovf = (occupancy == QUEUE_DEPTH) && !issue_ready;
                check_value({names[pend_row], ".overflow"}, 32'(expect_ovf), 32'(overflow));
                if (overflow) begin
                    overflow_count++;
                    dropped_row = pend_row;
                end else begin
                    pending_q.push_back('{row: pend_row, fetch_cycle: pend_cycle});
                end
                settled_count++;
            end else if (overflow) begin
                errors++;
                $display("ERROR: overflow pulsed with no entry arriving at the queue");
            end
            if (issue_valid) begin
                if (pending_q.size() == 0) begin
                    errors++;
                    $display("ERROR: an entry was issued with nothing outstanding");
                end else begin
                    p = pending_q.pop_front();
                    compare_entry(p);
                    issued_count++;
                end
            end
        end
        pend_fetch = fetch_valid;  // Decoded entry reaches the queue next cycle
        pend_row   = cur_row;
        pend_cycle = cycle;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > max_cycles) begin
            errors++;
            $display("ERROR: issue output stopped arriving, run ended after %0d cycles", cycle);
            report_and_finish();
        end
    end

    // ########################################################################
    // Stimulus
    // ########################################################################

    initial begin
        int ovf_before;
        void'($urandom(70));
        rst         = 1'b1;
        fetch_valid = 1'b0;
        instr_word  = '0;
        issue_ready = 1'b1;
        build_table();
        max_cycles = 20 * (2 * names.size() + 5) + 200;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(6);  // Outputs must stay quiet with no fetch

        // Directed pass with the execute stage always ready
        for (int i = 0; i < names.size(); i++) begin
            fetch_row(i);
            idle_cycles($urandom_range(2, 0));
        end
        wait_drained();
        check_value("directed.issued", names.size(), issued_count);

        // Random ready and random fetch gaps
        random_ready = 1'b1;
        for (int i = 0; i < names.size(); i++) begin
            fetch_row(i);
            idle_cycles($urandom_range(3, 0));
        end
        random_ready = 1'b0;
        issue_ready  = 1'b1;
        wait_drained();

        // Five back-to-back fetches into a stalled queue of four
        issue_ready = 1'b0;
        ovf_before  = overflow_count;
        for (int i = 1; i <= 5; i++)
            fetch_row(i);
        wait_settled();
        check_value("stall.overflows", 1, overflow_count - ovf_before);
        check_value("stall.dropped_row", 5, dropped_row);
        check_value("stall.held", 4, pending_q.size());
        issue_ready = 1'b1;
        wait_drained();

        report_and_finish();
    end

endmodule

//--- decode_stage.f
source/isa_pkg.sv
source/decode_pkg.sv
source/instr_classifier.sv
source/instr_decoder.sv
source/decode_queue.sv
source/issue_unit.sv
source/decode_stage.sv
bench/decode_stage_properties.sv
bench/decode_stage_tb.sv

//--- source/decode_pkg.sv
package decode_pkg;

    import isa_pkg::*;

    // ########################################################################
    // Queue sizing
    // ########################################################################

    localparam int QUEUE_DEPTH_DEFAULT = 4;

    // ########################################################################
    // Pipeline entries
    // ########################################################################

    // Decoder output as held in the queue, 44 bits
    typedef struct packed {
        instr_id_t id;
        format_t   format;
        ifunc_t    ifunc;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        imm_t      imm;
    } decoded_entry_t;

    // Entry handed to execute, with the write target resolved
    typedef struct packed {
        instr_id_t id;
        format_t   format;
        ifunc_t    ifunc;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        logic      reg_write;
        imm_t      imm;
    } issued_entry_t;

endpackage

//--- source/decode_queue.sv
`timescale 1ns/1ps

module decode_queue #(
    parameter int QUEUE_DEPTH = decode_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       entry_valid,
    input  decode_pkg::decoded_entry_t entry,
    input  logic                       pop,
    output decode_pkg::decoded_entry_t head,
    output logic                       empty,
    output logic                       overflow
);
    import decode_pkg::*;

    localparam int PTR_W   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0]   ptr_t;
    typedef logic [COUNT_W-1:0] count_t;

    decoded_entry_t mem [QUEUE_DEPTH];
    ptr_t           wr_ptr;
    ptr_t           rd_ptr;
    count_t         count;
    logic           full;
    logic           push;

    assign full     = (count == count_t'(QUEUE_DEPTH));
    assign empty    = (count == '0);
    assign push     = entry_valid && (!full || pop);  // A pop frees the slot this edge
    assign overflow = entry_valid && full && !pop;
    assign head     = mem[rd_ptr];

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= entry;
    end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
    parameter int QUEUE_DEPTH = decode_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_valid,
    input  isa_pkg::instr_word_t      instr_word,
    input  logic                      issue_ready,
    output logic                      issue_valid,
    output decode_pkg::issued_entry_t issued,
    output logic                      overflow
);
    import decode_pkg::*;

    logic           entry_valid;
    decoded_entry_t entry;
    decoded_entry_t head;
    logic           empty;
    logic           pop;

    instr_decoder decoder (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .instr_word  (instr_word),
        .entry_valid (entry_valid),
        .entry       (entry)
    );

    decode_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue (
        .clk         (clk),
        .rst         (rst),
        .entry_valid (entry_valid),
        .entry       (entry),
        .pop         (pop),
        .head        (head),
        .empty       (empty),
        .overflow    (overflow)
    );

    issue_unit issue (
        .clk         (clk),
        .rst         (rst),
        .head        (head),
        .empty       (empty),
        .issue_ready (issue_ready),
        .pop         (pop),
        .issue_valid (issue_valid),
        .issued      (issued)
    );

endmodule

//--- source/instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier (
    input  isa_pkg::instr_id_t id,
    output isa_pkg::format_t   format,
    output isa_pkg::ifunc_t    ifunc
);
    import isa_pkg::*;

    logic is_r;
    logic is_i;
    logic is_j;
    logic alu_r;
    logic alu_i;
    logic mem_r;
    logic mem_w;
    logic br;
    logic jmp;
    logic md;
    logic cp0;

    // ALU register ops are the whole R group
    assign alu_r = id inside {INSTR_NOP, INSTR_ADD, INSTR_SUB, INSTR_ADDU, INSTR_SUBU,
                              INSTR_AND, INSTR_OR, INSTR_XOR, INSTR_NOR, INSTR_SLT,
                              INSTR_SLTU, INSTR_SLL, INSTR_SLLV, INSTR_SRL, INSTR_SRLV,
                              INSTR_SRA, INSTR_SRAV, INSTR_CLO, INSTR_CLZ};
    assign alu_i = id inside {INSTR_ADDI, INSTR_ADDIU, INSTR_ANDI, INSTR_ORI,
                              INSTR_XORI, INSTR_LUI, INSTR_SLTI, INSTR_SLTIU};
    assign mem_r = id inside {INSTR_LW, INSTR_LH, INSTR_LHU, INSTR_LB, INSTR_LBU};
    assign mem_w = id inside {INSTR_SW, INSTR_SH, INSTR_SB};
    assign br    = id inside {INSTR_BEQ, INSTR_BNE, INSTR_BLEZ, INSTR_BGTZ, INSTR_BGEZ,
                              INSTR_BLTZ, INSTR_BGEZAL, INSTR_BLTZAL};
    assign jmp   = id inside {INSTR_J, INSTR_JAL, INSTR_JALR, INSTR_JR};
    assign md    = id inside {INSTR_MULT, INSTR_MULTU, INSTR_DIV, INSTR_DIVU,
                              INSTR_MFHI, INSTR_MFLO, INSTR_MTHI, INSTR_MTLO,
                              INSTR_MADD, INSTR_MADDU, INSTR_MSUB, INSTR_MSUBU};
    assign cp0   = id inside {INSTR_MFC0, INSTR_MTC0, INSTR_ERET};

    assign is_r = alu_r;
    assign is_i = alu_i | mem_r | mem_w | br;  // Every immediate-carrying group
    assign is_j = id inside {INSTR_J, INSTR_JAL};  // JR and JALR fall back to R

    always_comb begin
        if (is_r)
            format = FORMAT_R;
        else if (is_i)
            format = FORMAT_I;
        else if (is_j)
            format = FORMAT_J;
        else
            format = FORMAT_R;
    end

    always_comb begin
        if (alu_r)
            ifunc = I_ALU_R;
        else if (alu_i)
            ifunc = I_ALU_I;
        else if (mem_r)
            ifunc = I_MEM_R;
        else if (mem_w)
            ifunc = I_MEM_W;
        else if (br)
            ifunc = I_BRANCH;
        else if (jmp)
            ifunc = I_JUMP;
        else if (md)
            ifunc = I_MD;
        else if (cp0)
            ifunc = I_CP0;
        else
            ifunc = I_OTHER;
    end

endmodule

//--- source/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_valid,
    input  isa_pkg::instr_word_t       instr_word,
    output logic                       entry_valid,
    output decode_pkg::decoded_entry_t entry
);
    import isa_pkg::*;
    import decode_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    imm_t      imm;
    instr_id_t id;
    format_t   format;
    ifunc_t    ifunc;

    assign opcode = instr_word[31:26];
    assign rs     = instr_word[25:21];
    assign rt     = instr_word[20:16];
    assign rd     = instr_word[15:11];
    assign funct  = instr_word[5:0];
    assign imm    = instr_word[15:0];

    // ########################################################################
    // Word to identifier
    // ########################################################################

    always_comb begin
        id = INSTR_INVALID;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL:   id = (instr_word == '0) ? INSTR_NOP : INSTR_SLL;
                    FN_SRL:   id = INSTR_SRL;
                    FN_SRA:   id = INSTR_SRA;
                    FN_SLLV:  id = INSTR_SLLV;
                    FN_SRLV:  id = INSTR_SRLV;
                    FN_SRAV:  id = INSTR_SRAV;
                    FN_JR:    id = INSTR_JR;
                    FN_JALR:  id = INSTR_JALR;
                    FN_MFHI:  id = INSTR_MFHI;
                    FN_MTHI:  id = INSTR_MTHI;
                    FN_MFLO:  id = INSTR_MFLO;
                    FN_MTLO:  id = INSTR_MTLO;
                    FN_MULT:  id = INSTR_MULT;
                    FN_MULTU: id = INSTR_MULTU;
                    FN_DIV:   id = INSTR_DIV;
                    FN_DIVU:  id = INSTR_DIVU;
                    FN_ADD:   id = INSTR_ADD;
                    FN_ADDU:  id = INSTR_ADDU;
                    FN_SUB:   id = INSTR_SUB;
                    FN_SUBU:  id = INSTR_SUBU;
                    FN_AND:   id = INSTR_AND;
                    FN_OR:    id = INSTR_OR;
                    FN_XOR:   id = INSTR_XOR;
                    FN_NOR:   id = INSTR_NOR;
                    FN_SLT:   id = INSTR_SLT;
                    FN_SLTU:  id = INSTR_SLTU;
                    default:  id = INSTR_INVALID;
                endcase
            end
            OP_SPECIAL2: begin
                case (funct)
                    FN_MADD:  id = INSTR_MADD;
                    FN_MADDU: id = INSTR_MADDU;
                    FN_MSUB:  id = INSTR_MSUB;
                    FN_MSUBU: id = INSTR_MSUBU;
                    FN_CLZ:   id = INSTR_CLZ;
                    FN_CLO:   id = INSTR_CLO;
                    default:  id = INSTR_INVALID;
                endcase
            end
            OP_REGIMM: begin
                case (rt)
                    RT_BLTZ:   id = INSTR_BLTZ;
                    RT_BGEZ:   id = INSTR_BGEZ;
                    RT_BLTZAL: id = INSTR_BLTZAL;
                    RT_BGEZAL: id = INSTR_BGEZAL;
                    default:   id = INSTR_INVALID;
                endcase
            end
            OP_COP0: begin
                if (rs == RS_MF)
                    id = INSTR_MFC0;
                else if (rs == RS_MT)
                    id = INSTR_MTC0;
                else if (rs == RS_CO && funct == FN_ERET)
                    id = INSTR_ERET;
            end
            OP_J:     id = INSTR_J;
            OP_JAL:   id = INSTR_JAL;
            OP_BEQ:   id = INSTR_BEQ;
            OP_BNE:   id = INSTR_BNE;
            OP_BLEZ:  id = INSTR_BLEZ;
            OP_BGTZ:  id = INSTR_BGTZ;
            OP_ADDI:  id = INSTR_ADDI;
            OP_ADDIU: id = INSTR_ADDIU;
            OP_SLTI:  id = INSTR_SLTI;
            OP_SLTIU: id = INSTR_SLTIU;
            OP_ANDI:  id = INSTR_ANDI;
            OP_ORI:   id = INSTR_ORI;
            OP_XORI:  id = INSTR_XORI;
            OP_LUI:   id = INSTR_LUI;
            OP_LB:    id = INSTR_LB;
            OP_LH:    id = INSTR_LH;
            OP_LW:    id = INSTR_LW;
            OP_LBU:   id = INSTR_LBU;
            OP_LHU:   id = INSTR_LHU;
            OP_SB:    id = INSTR_SB;
            OP_SH:    id = INSTR_SH;
            OP_SW:    id = INSTR_SW;
            default:  id = INSTR_INVALID;
        endcase
    end

    instr_classifier classifier (
        .id     (id),
        .format (format),
        .ifunc  (ifunc)
    );

    always_ff @(posedge clk) begin
        if (rst)
            entry_valid <= 1'b0;
        else
            entry_valid <= fetch_valid;  // Fixed one-cycle decode
    end

    always_ff @(posedge clk) begin
        if (fetch_valid)
            entry <= '{id: id, format: format, ifunc: ifunc,
                       rs: rs, rt: rt, rd: rd, imm: imm};
    end

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

    // ########################################################################
    // Field widths
    // ########################################################################

    typedef logic [31:0] instr_word_t;
    typedef logic [6:0]  instr_id_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [1:0]  format_t;
    typedef logic [3:0]  ifunc_t;

    localparam reg_addr_t REG_RA = 5'd31;  // Link register for JAL and the AL branches

    // ########################################################################
    // Instruction identifiers, grouped by functional class
    // ########################################################################

    localparam instr_id_t
        INSTR_NOP    = 7'd0,  INSTR_ADD    = 7'd1,  INSTR_SUB    = 7'd2,  INSTR_ADDU   = 7'd3,
        INSTR_SUBU   = 7'd4,  INSTR_AND    = 7'd5,  INSTR_OR     = 7'd6,  INSTR_XOR    = 7'd7,
        INSTR_NOR    = 7'd8,  INSTR_SLT    = 7'd9,  INSTR_SLTU   = 7'd10, INSTR_SLL    = 7'd11,
        INSTR_SLLV   = 7'd12, INSTR_SRL    = 7'd13, INSTR_SRLV   = 7'd14, INSTR_SRA    = 7'd15,
        INSTR_SRAV   = 7'd16, INSTR_CLO    = 7'd17, INSTR_CLZ    = 7'd18,
        INSTR_ADDI   = 7'd20, INSTR_ADDIU  = 7'd21, INSTR_ANDI   = 7'd22, INSTR_ORI    = 7'd23,
        INSTR_XORI   = 7'd24, INSTR_LUI    = 7'd25, INSTR_SLTI   = 7'd26, INSTR_SLTIU  = 7'd27,
        INSTR_LW     = 7'd32, INSTR_LH     = 7'd33, INSTR_LHU    = 7'd34, INSTR_LB     = 7'd35,
        INSTR_LBU    = 7'd36,
        INSTR_SW     = 7'd40, INSTR_SH     = 7'd41, INSTR_SB     = 7'd42,
        INSTR_BEQ    = 7'd48, INSTR_BNE    = 7'd49, INSTR_BLEZ   = 7'd50, INSTR_BGTZ   = 7'd51,
        INSTR_BGEZ   = 7'd52, INSTR_BLTZ   = 7'd53, INSTR_BGEZAL = 7'd54, INSTR_BLTZAL = 7'd55,
        INSTR_J      = 7'd64, INSTR_JAL    = 7'd65, INSTR_JALR   = 7'd66, INSTR_JR     = 7'd67,
        INSTR_MULT   = 7'd72, INSTR_MULTU  = 7'd73, INSTR_DIV    = 7'd74, INSTR_DIVU   = 7'd75,
        INSTR_MFHI   = 7'd76, INSTR_MFLO   = 7'd77, INSTR_MTHI   = 7'd78, INSTR_MTLO   = 7'd79,
        INSTR_MADD   = 7'd80, INSTR_MADDU  = 7'd81, INSTR_MSUB   = 7'd82, INSTR_MSUBU  = 7'd83,
        INSTR_MFC0   = 7'd96, INSTR_MTC0   = 7'd97, INSTR_ERET   = 7'd98,
        INSTR_INVALID = 7'd127;  // Any word that matches nothing above

    localparam format_t FORMAT_R = 2'd0;
    localparam format_t FORMAT_I = 2'd1;
    localparam format_t FORMAT_J = 2'd2;

    localparam ifunc_t
        I_ALU_R  = 4'd0, I_ALU_I = 4'd1, I_MEM_R = 4'd2, I_MEM_W = 4'd3,
        I_BRANCH = 4'd4, I_JUMP  = 4'd5, I_MD    = 4'd6, I_CP0   = 4'd7,
        I_OTHER  = 4'd8;

    // ########################################################################
    // Encoding fields
    // ########################################################################

    localparam opcode_t
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_COP0    = 6'h10, OP_SPECIAL2 = 6'h1c,
        OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
        OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b;

    // Funct values under OP_SPECIAL
    localparam funct_t
        FN_SLL  = 6'h00, FN_SRL   = 6'h02, FN_SRA  = 6'h03, FN_SLLV  = 6'h04,
        FN_SRLV = 6'h06, FN_SRAV  = 6'h07, FN_JR   = 6'h08, FN_JALR  = 6'h09,
        FN_MFHI = 6'h10, FN_MTHI  = 6'h11, FN_MFLO = 6'h12, FN_MTLO  = 6'h13,
        FN_MULT = 6'h18, FN_MULTU = 6'h19, FN_DIV  = 6'h1a, FN_DIVU  = 6'h1b,
        FN_ADD  = 6'h20, FN_ADDU  = 6'h21, FN_SUB  = 6'h22, FN_SUBU  = 6'h23,
        FN_AND  = 6'h24, FN_OR    = 6'h25, FN_XOR  = 6'h26, FN_NOR   = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU  = 6'h2b;

    // Funct values under OP_SPECIAL2 and OP_COP0
    localparam funct_t
        FN_MADD = 6'h00, FN_MADDU = 6'h01, FN_MSUB = 6'h04, FN_MSUBU = 6'h05,
        FN_CLZ  = 6'h20, FN_CLO   = 6'h21, FN_ERET = 6'h18;

    // REGIMM selects by rt, COP0 selects by rs
    localparam reg_addr_t
        RT_BLTZ = 5'h00, RT_BGEZ = 5'h01, RT_BLTZAL = 5'h10, RT_BGEZAL = 5'h11,
        RS_MF   = 5'h00, RS_MT   = 5'h04, RS_CO     = 5'h10;

endpackage

//--- source/issue_unit.sv
`timescale 1ns/1ps

module issue_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  decode_pkg::decoded_entry_t head,
    input  logic                       empty,
    input  logic                       issue_ready,
    output logic                       pop,
    output logic                       issue_valid,
    output decode_pkg::issued_entry_t  issued
);
    import isa_pkg::*;
    import decode_pkg::*;

    reg_addr_t dest;
    logic      has_dest;

    assign pop = !empty && issue_ready;

    always_comb begin
        dest     = '0;
        has_dest = 1'b0;
        case (head.ifunc)
            I_ALU_R: begin
                dest     = head.rd;
                has_dest = 1'b1;
            end
            I_ALU_I, I_MEM_R: begin
                dest     = head.rt;
                has_dest = 1'b1;
            end
            I_MD: begin
                dest     = head.rd;
                has_dest = head.id inside {INSTR_MFHI, INSTR_MFLO};
            end
            I_JUMP: begin
                dest     = (head.id == INSTR_JALR) ? head.rd : REG_RA;
                has_dest = head.id inside {INSTR_JALR, INSTR_JAL};
            end
            I_BRANCH: begin
                dest     = REG_RA;  // Only the linking branches write it
                has_dest = head.id inside {INSTR_BGEZAL, INSTR_BLTZAL};
            end
            I_CP0: begin
                dest     = head.rt;
                has_dest = (head.id == INSTR_MFC0);
            end
            default: begin
                dest     = '0;
                has_dest = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            issue_valid <= 1'b0;
        else
            issue_valid <= pop;
    end

    always_ff @(posedge clk) begin
        if (pop)
            issued <= '{id: head.id, format: head.format, ifunc: head.ifunc,
                        rs: head.rs, rt: head.rt, dest: dest,
                        reg_write: has_dest && (dest != '0), imm: head.imm};
    end

endmodule
